//--- verilog/ps2_mouse_pkg.sv
package ps2_mouse_pkg;

  // one byte on the ps/2 wire.
  typedef logic [7:0] byte_t;

  // three-byte movement packet, status first.
  typedef struct packed {
    byte_t status;
    byte_t x;
    byte_t y;
  } mouse_packet_t;

  // filtered view of the bus.
  typedef struct packed {
    logic clk_fall; // one cycle per filtered falling edge.
    logic data;
  } ps2_sample_t;

  // cpu register map.
  typedef enum logic [1:0] {
    reg_status = 2'd0,
    reg_x      = 2'd1,
    reg_y      = 2'd2,
    reg_error  = 2'd3
  } reg_addr_t;

  localparam byte_t cmd_enable_reporting = 8'hF4;
  localparam byte_t rsp_ack              = 8'hFA;

endpackage

//--- verilog/ps2_line_arbiter.sv
module ps2_line_arbiter import ps2_mouse_pkg::*; #(
  parameter int unsigned FILTER_LEN = 4
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        ps2_clk_in,
  input  logic        ps2_data_in,
  input  logic        tx_req,
  input  logic        rx_busy,
  input  logic        clk_low,
  input  logic        data_low,
  output logic        tx_grant,
  output ps2_sample_t sample,
  output ps2_sample_t rx_sample,
  output logic        ps2_clk_drive_low,
  output logic        ps2_data_drive_low
);

  localparam int unsigned FLT_W = $clog2(FILTER_LEN + 1);

  typedef enum logic {
    owner_rx,
    owner_tx
  } owner_t;

  owner_t           owner;
  logic [1:0]       clk_sync;
  logic [1:0]       data_sync;
  logic [FLT_W-1:0] flt_cnt;
  logic             clk_filt;
  logic             clk_filt_q;

  // idle bus is high, so everything resets to one.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_sync   <= 2'b11;
      data_sync  <= 2'b11;
      flt_cnt    <= '0;
      clk_filt   <= 1'b1;
      clk_filt_q <= 1'b1;
    end else begin
      clk_sync   <= {clk_sync[0], ps2_clk_in};
      data_sync  <= {data_sync[0], ps2_data_in};
      clk_filt_q <= clk_filt;
      if (clk_sync[1] == clk_filt) begin
        flt_cnt <= '0;
      end else if (flt_cnt == FLT_W'(FILTER_LEN - 1)) begin
        clk_filt <= clk_sync[1]; // level held long enough.
        flt_cnt  <= '0;
      end else begin
        flt_cnt <= flt_cnt + 1'b1;
      end
    end
  end

  // tx only gets the bus between rx frames.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      owner <= owner_rx;
    end else begin
      case (owner)
        owner_rx: if (tx_req && !rx_busy) owner <= owner_tx;
        owner_tx: if (!tx_req) owner <= owner_rx;
        default:  owner <= owner_rx;
      endcase
    end
  end

  assign tx_grant = (owner == owner_tx);

  assign sample.clk_fall    = clk_filt_q & ~clk_filt;
  assign sample.data        = data_sync[1];
  assign rx_sample.clk_fall = sample.clk_fall & ~tx_grant; // hide host-driven edges.
  assign rx_sample.data     = sample.data;

  assign ps2_clk_drive_low  = tx_grant & clk_low;
  assign ps2_data_drive_low = tx_grant & data_low;

endmodule

//--- verilog/ps2_rx.sv
module ps2_rx import ps2_mouse_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  ps2_sample_t sample,
  output byte_t       rx_byte,
  output logic        byte_valid,
  output logic        parity_err,
  output logic        rx_busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_shift,
    st_stop
  } rx_state_t;

  rx_state_t  state;
  logic [3:0] bit_cnt;
  logic [8:0] frame; // parity in bit 8, data lsb first below.
  logic       frame_ok;

  // odd parity over data and parity bit, stop bit must be high.
  assign frame_ok = (^frame) & sample.data;

  // 11 edges per frame.
  // start in idle, 8 data plus parity in shift, stop in stop.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= st_idle;
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
      parity_err <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      parity_err <= 1'b0;
      if (sample.clk_fall) begin
        case (state)
          st_idle: begin
            if (!sample.data) begin // high start bit is ignored.
              state   <= st_shift;
              bit_cnt <= '0;
            end
          end
          st_shift: begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd8) begin
              state <= st_stop;
            end
          end
          st_stop: begin
            byte_valid <= frame_ok;
            parity_err <= ~frame_ok;
            state      <= st_idle;
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample.clk_fall && state == st_shift) begin
      frame <= {sample.data, frame[8:1]};
    end
  end

  assign rx_byte = frame[7:0];
  assign rx_busy = (state != st_idle);

endmodule

//--- verilog/ps2_tx.sv
module ps2_tx import ps2_mouse_pkg::*; #(
  parameter int unsigned INHIBIT_CYCLES = 64
) (
  input  logic        clk,
  input  logic        arst_n,
  input  ps2_sample_t sample,
  input  logic        send_start,
  input  byte_t       cmd,
  input  logic        tx_grant,
  output logic        tx_req,
  output logic        clk_low,
  output logic        data_low,
  output logic        tx_done,
  output logic        tx_ack_err
);

  localparam int unsigned INH_W = $clog2(INHIBIT_CYCLES + 1);

  typedef enum logic [2:0] {
    st_idle,
    st_request,
    st_inhibit,
    st_rts,
    st_shift
  } tx_state_t;

  tx_state_t        state;
  logic [INH_W-1:0] inh_cnt;
  logic [3:0]       bit_cnt;
  logic [10:0]      tx_frame; // stop, parity, data, start.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= st_idle;
      inh_cnt    <= '0;
      bit_cnt    <= '0;
      tx_req     <= 1'b0;
      tx_done    <= 1'b0;
      tx_ack_err <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      case (state)
        st_idle: begin
          if (send_start) begin
            tx_req <= 1'b1;
            state  <= st_request;
          end
        end
        st_request: begin
          if (tx_grant) begin
            inh_cnt <= '0;
            state   <= st_inhibit;
          end
        end
        st_inhibit: begin
          if (inh_cnt == INH_W'(INHIBIT_CYCLES - 1)) begin
            state <= st_rts;
          end else begin
            inh_cnt <= inh_cnt + 1'b1;
          end
        end
        st_rts: begin // data low while clock is still held.
          bit_cnt <= '0;
          state   <= st_shift;
        end
        st_shift: begin
          if (sample.clk_fall) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd10) begin
              // eleventh edge carries the device ack.
              tx_ack_err <= sample.data;
              tx_done    <= 1'b1;
              tx_req     <= 1'b0;
              state      <= st_idle;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // next bit goes out after each device falling edge.
  always_ff @(posedge clk) begin
    if (state == st_idle && send_start) begin
      tx_frame <= {1'b1, ~^cmd, cmd, 1'b0};
    end else if (state == st_shift && sample.clk_fall) begin
      tx_frame <= {1'b1, tx_frame[10:1]};
    end
  end

  assign clk_low  = (state == st_inhibit) || (state == st_rts);
  assign data_low = ((state == st_rts) || (state == st_shift)) & ~tx_frame[0];

endmodule

//--- verilog/ps2_packet_ctrl.sv
module ps2_packet_ctrl import ps2_mouse_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      byte_valid,
  input  logic      parity_err,
  input  logic      tx_done,
  input  byte_t     rx_byte,
  input  logic      io_cs,
  input  reg_addr_t addr,
  output logic      send_start,
  output byte_t     cmd,
  output byte_t     rd_data,
  output logic      dav,
  output logic      ack_seen
);

  typedef enum logic [1:0] {
    send_cmd,
    wait_done,
    wait_ack,
    packets
  } ctrl_state_t;

  ctrl_state_t   state;
  logic [1:0]    byte_cnt;
  logic          err_flag;
  logic          pkt_done;
  mouse_packet_t stage;
  mouse_packet_t pkt;

  assign cmd      = cmd_enable_reporting;
  assign pkt_done = (state == packets) && byte_valid && (byte_cnt == 2'd2);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= send_cmd;
      byte_cnt   <= '0;
      send_start <= 1'b0;
      ack_seen   <= 1'b0;
      dav        <= 1'b0;
      err_flag   <= 1'b0;
    end else begin
      send_start <= 1'b0;
      ack_seen   <= 1'b0;
      case (state)
        send_cmd: begin
          send_start <= 1'b1;
          state      <= wait_done;
        end
        wait_done: if (tx_done) state <= wait_ack;
        wait_ack: begin
          if (byte_valid && rx_byte == rsp_ack) begin
            ack_seen <= 1'b1;
            state    <= packets;
          end
        end
        packets: begin
          if (parity_err) begin
            byte_cnt <= '0; // drop partial packet.
          end else if (byte_valid) begin
            byte_cnt <= (byte_cnt == 2'd2) ? 2'd0 : byte_cnt + 2'd1;
          end
        end
        default: state <= send_cmd;
      endcase

      // reads clear, new events win.
      if (io_cs && addr == reg_y) dav <= 1'b0;
      if (pkt_done) dav <= 1'b1;
      if (io_cs && addr == reg_error) err_flag <= 1'b0;
      if (parity_err) err_flag <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (state == packets && byte_valid) begin
      case (byte_cnt)
        2'd0:    stage.status <= rx_byte;
        2'd1:    stage.x      <= rx_byte;
        default: stage.y      <= rx_byte;
      endcase
    end
    if (pkt_done) begin
      pkt <= '{status: stage.status, x: stage.x, y: rx_byte};
    end
  end

  always_comb begin
    rd_data = '0;
    if (io_cs) begin
      case (addr)
        reg_status: rd_data = pkt.status;
        reg_x:      rd_data = pkt.x;
        reg_y:      rd_data = pkt.y;
        reg_error:  rd_data = {7'd0, err_flag};
        default:    rd_data = '0;
      endcase
    end
  end

endmodule

//--- verilog/ps2_mouse.sv
module ps2_mouse import ps2_mouse_pkg::*; #(
  parameter int unsigned FILTER_LEN     = 4,
  parameter int unsigned INHIBIT_CYCLES = 64
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      ps2_clk_in,
  input  logic      ps2_data_in,
  output logic      ps2_clk_drive_low,
  output logic      ps2_data_drive_low,
  input  logic      io_cs,
  input  reg_addr_t addr,
  output byte_t     rd_data,
  output logic      dav,
  output logic      tx_done,
  output logic      ack_seen
);

  ps2_sample_t sample;
  ps2_sample_t rx_sample;
  logic        tx_grant;
  logic        tx_req;
  logic        clk_low;
  logic        data_low;
  logic        rx_busy;
  logic        byte_valid;
  logic        parity_err;
  logic        send_start;
  byte_t       rx_byte;
  byte_t       cmd;

  ps2_line_arbiter #(
    .FILTER_LEN(FILTER_LEN)
  ) i_arbiter (
    .clk                (clk),
    .arst_n             (arst_n),
    .ps2_clk_in         (ps2_clk_in),
    .ps2_data_in        (ps2_data_in),
    .tx_req             (tx_req),
    .rx_busy            (rx_busy),
    .clk_low            (clk_low),
    .data_low           (data_low),
    .tx_grant           (tx_grant),
    .sample             (sample),
    .rx_sample          (rx_sample),
    .ps2_clk_drive_low  (ps2_clk_drive_low),
    .ps2_data_drive_low (ps2_data_drive_low)
  );

  ps2_rx i_rx (
    .clk        (clk),
    .arst_n     (arst_n),
    .sample     (rx_sample),
    .rx_byte    (rx_byte),
    .byte_valid (byte_valid),
    .parity_err (parity_err),
    .rx_busy    (rx_busy)
  );

  // ack error is not mapped to a register.
  ps2_tx #(
    .INHIBIT_CYCLES(INHIBIT_CYCLES)
  ) i_tx (
    .clk        (clk),
    .arst_n     (arst_n),
    .sample     (sample),
    .send_start (send_start),
    .cmd        (cmd),
    .tx_grant   (tx_grant),
    .tx_req     (tx_req),
    .clk_low    (clk_low),
    .data_low   (data_low),
    .tx_done    (tx_done),
    .tx_ack_err ()
  );

  ps2_packet_ctrl i_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .byte_valid (byte_valid),
    .parity_err (parity_err),
    .tx_done    (tx_done),
    .rx_byte    (rx_byte),
    .io_cs      (io_cs),
    .addr       (addr),
    .send_start (send_start),
    .cmd        (cmd),
    .rd_data    (rd_data),
    .dav        (dav),
    .ack_seen   (ack_seen)
  );

endmodule

//--- dv/ps2_device_model.sv
module ps2_device_model (
  input  logic clk,
  input  logic ps2_clk,  // resolved bus levels.
  input  logic ps2_data,
  output logic clk_low,
  output logic data_low
);

  localparam int half_cycles = 8;

  initial begin
    clk_low  = 1'b0;
    data_low = 1'b0;
  end

  task automatic half_period();
    repeat (half_cycles) @(posedge clk);
    #2;
  endtask

  // device to host frame, data set while the clock is high.
  task automatic send_byte(input logic [7:0] value, input logic bad_parity);
    logic [10:0] frame;
    logic        par;
    par   = ~^value ^ bad_parity;
    frame = {1'b1, par, value, 1'b0};
    for (int i = 0; i < 11; i++) begin
      data_low = ~frame[i];
      half_period();
      clk_low = 1'b1;
      half_period();
      clk_low = 1'b0;
    end
    data_low = 1'b0;
    half_period(); // idle gap.
    half_period();
  endtask

  // host to device frame, returns the byte plus parity and stop bits.
  task automatic receive_cmd(output logic [7:0] value, output logic par,
                             output logic stop);
    logic [9:0] bits;
    @(posedge clk);
    while (ps2_clk) @(posedge clk); // inhibit.
    while (!(ps2_clk && !ps2_data)) @(posedge clk); // request to send.
    #2;
    half_period();
    for (int i = 0; i < 10; i++) begin
      clk_low = 1'b1;
      half_period();
      clk_low = 1'b0;
      half_period();
      bits[i] = ps2_data; // bit shown after this fall.
    end
    value    = bits[7:0];
    par      = bits[8];
    stop     = bits[9];
    data_low = 1'b1; // acknowledge.
    clk_low  = 1'b1;
    half_period();
    clk_low  = 1'b0;
    half_period();
    data_low = 1'b0;
    half_period();
    half_period();
  endtask

endmodule

//--- dv/tb_ps2_mouse.sv
module tb_ps2_mouse import ps2_mouse_pkg::*; ();

  localparam int frame_cycles   = 11 * 16 + 32;
  localparam int n_frames       = 25;
  localparam int timeout_cycles = 4 * frame_cycles * n_frames + 2000;

  logic      clk;
  logic      arst_n;
  logic      io_cs;
  reg_addr_t addr;
  byte_t     rd_data;
  logic      dav;
  logic      tx_done;
  logic      ack_seen;
  logic      host_clk_low;
  logic      host_data_low;
  logic      dev_clk_low;
  logic      dev_data_low;
  logic      ps2_clk_in;
  logic      ps2_data_in;
  int        errors;
  int        checks;
  int        cycles;
  int        tx_done_cnt;
  int        ack_cnt;
  logic [31:0] lfsr;

  // open-drain bus.
  assign ps2_clk_in  = ~(host_clk_low | dev_clk_low);
  assign ps2_data_in = ~(host_data_low | dev_data_low);

  ps2_mouse i_dut (
    .clk                (clk),
    .arst_n             (arst_n),
    .ps2_clk_in         (ps2_clk_in),
    .ps2_data_in        (ps2_data_in),
    .ps2_clk_drive_low  (host_clk_low),
    .ps2_data_drive_low (host_data_low),
    .io_cs              (io_cs),
    .addr               (addr),
    .rd_data            (rd_data),
    .dav                (dav),
    .tx_done            (tx_done),
    .ack_seen           (ack_seen)
  );

  ps2_device_model i_device (
    .clk      (clk),
    .ps2_clk  (ps2_clk_in),
    .ps2_data (ps2_data_in),
    .clk_low  (dev_clk_low),
    .data_low (dev_data_low)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(negedge clk) begin
    cycles++;
    if (tx_done) tx_done_cnt++;
    if (ack_seen) ack_cnt++;
    if (cycles >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit taken.
  task automatic next_byte(output byte_t b);
    for (int i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                          input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic read_reg(input reg_addr_t a, output byte_t data);
    @(posedge clk);
    #2;
    io_cs = 1'b1;
    addr  = a;
    @(negedge clk);
    data = rd_data;
    @(posedge clk);
    #2;
    io_cs = 1'b0;
  endtask

  task automatic wait_dav();
    int n;
    n = 0;
    while (!dav && n < 200) begin
      @(negedge clk);
      n++;
    end
    check_eq(dav, 1'b1, "dav after packet");
  endtask

  task automatic send_and_read(input byte_t s, input byte_t x, input byte_t y);
    byte_t d;
    i_device.send_byte(s, 1'b0);
    i_device.send_byte(x, 1'b0);
    i_device.send_byte(y, 1'b0);
    wait_dav();
    read_reg(reg_status, d);
    check_eq(d, s, "status byte");
    read_reg(reg_x, d);
    check_eq(d, x, "x byte");
    read_reg(reg_y, d);
    check_eq(d, y, "y byte");
    @(negedge clk);
    check_eq(dav, 1'b0, "dav after y read");
  endtask

  task automatic reset_outputs_idle();
    @(negedge clk);
    check_eq(host_clk_low, 1'b0, "clk drive after reset");
    check_eq(host_data_low, 1'b0, "data drive after reset");
    check_eq({dav, tx_done, ack_seen}, 3'b000, "flags after reset");
  endtask

  task automatic init_sequence();
    byte_t v;
    logic  par;
    logic  stop;
    int    n;
    i_device.receive_cmd(v, par, stop);
    check_eq(v, 8'hF4, "command byte");
    check_eq(par, 1'b0, "command parity"); // f4 already has five ones.
    check_eq(stop, 1'b1, "command stop bit");
    check_eq(tx_done_cnt, 1, "tx_done pulses");
    i_device.send_byte(8'hFA, 1'b0);
    n = 0;
    while (ack_cnt == 0 && n < 100) begin
      @(negedge clk);
      n++;
    end
    check_eq(ack_cnt, 1, "ack_seen pulses");
  endtask

  task automatic parity_error_recovery();
    byte_t d;
    i_device.send_byte(8'h77, 1'b0); // partial packet to be dropped.
    i_device.send_byte(8'h5A, 1'b1);
    read_reg(reg_error, d);
    check_eq(d, 8'h01, "error flag set");
    read_reg(reg_error, d);
    check_eq(d, 8'h00, "error flag cleared");
    send_and_read(8'h12, 8'h34, 8'h56);
  endtask

  task automatic random_packets();
    byte_t s;
    byte_t x;
    byte_t y;
    for (int p = 0; p < 4; p++) begin
      next_byte(s);
      next_byte(x);
      next_byte(y);
      send_and_read(s, x, y);
    end
  endtask

  initial begin
    arst_n      = 1'b0;
    io_cs       = 1'b0;
    addr        = reg_status;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    tx_done_cnt = 0;
    ack_cnt     = 0;
    lfsr        = 32'h3818;
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
    reset_outputs_idle();
    init_sequence();
    send_and_read(8'hAB, 8'hBC, 8'hCD);
    send_and_read(8'hCD, 8'hBC, 8'hAB);
    parity_error_recovery();
    random_packets();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- ps2_mouse.f
verilog/ps2_mouse_pkg.sv
verilog/ps2_line_arbiter.sv
verilog/ps2_rx.sv
verilog/ps2_tx.sv
verilog/ps2_packet_ctrl.sv
verilog/ps2_mouse.sv
dv/ps2_device_model.sv
dv/tb_ps2_mouse.sv

//--- Bender.yml
package:
  name: ps2_mouse

sources:
  - files:
      - verilog/ps2_mouse_pkg.sv
      - verilog/ps2_line_arbiter.sv
      - verilog/ps2_rx.sv
      - verilog/ps2_tx.sv
      - verilog/ps2_packet_ctrl.sv
      - verilog/ps2_mouse.sv
  - target: test
    files:
      - dv/ps2_device_model.sv
      - dv/tb_ps2_mouse.sv
